// ==== logic/cpuPkg.sv ====
// CPU package with word sizes, instruction fields, opcodes and the records passed between stages
`default_nettype none

package cpuPkg;

   localparam int dataWidth = 16;
   localparam int addrWidth = 8;
   localparam int regCount = 8;
   localparam int regIndexWidth = 3;

   // Loads and stores always land in the upper half of memory
   localparam int dataBase = 128;

   // Instruction field widths and positions
   localparam int opcodeWidth = 4;
   localparam int imm6Width = 6;
   localparam int opcodeLsb = 12;
   localparam int rdLsb = 9;
   localparam int rsLsb = 6;
   localparam int rtLsb = 3;

   // Codes 9 to 15 are illegal
   typedef enum logic [opcodeWidth-1:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_XOR  = 4'h3,
      OP_ADDI = 4'h4,
      OP_LD   = 4'h5,
      OP_ST   = 4'h6,
      OP_BEQZ = 4'h7,
      OP_HALT = 4'h8
   } opcodeT;

   typedef struct packed {
      logic                 valid;
      logic                 write;
      logic [addrWidth-1:0] addr;
      logic [dataWidth-1:0] wdata;
   } memReqT;

   typedef struct packed {
      logic                 valid;
      logic [addrWidth-1:0] pc;
      logic [dataWidth-1:0] instr;
   } fetchOutT;

   typedef struct packed {
      logic                     valid;
      logic [addrWidth-1:0]     pc;
      opcodeT                   op;
      logic [regIndexWidth-1:0] rd;
      logic [dataWidth-1:0]     opA;
      logic [dataWidth-1:0]     opB;
      logic [dataWidth-1:0]     storeData;
      logic                     writesReg;
   } decodeOutT;

   // Result holds the ALU value, or the data address for LD and ST
   typedef struct packed {
      logic                     valid;
      logic [addrWidth-1:0]     pc;
      opcodeT                   op;
      logic [regIndexWidth-1:0] rd;
      logic [dataWidth-1:0]     result;
      logic [dataWidth-1:0]     storeData;
      logic                     writesReg;
   } execOutT;

   // Addr is the full memory address of a store
   typedef struct packed {
      logic                     valid;
      logic [addrWidth-1:0]     pc;
      logic                     writesReg;
      logic [regIndexWidth-1:0] destReg;
      logic [dataWidth-1:0]     value;
      logic                     writesMem;
      logic [addrWidth-1:0]     addr;
      logic [dataWidth-1:0]     storeData;
   } traceT;

endpackage

`default_nettype wire

// ==== logic/decodeStage.sv ====
// Decode stage with the register file, field split, hazard interlock and decode-to-execute register
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
   input  logic                               clk,
   input  logic                               reset,
   input  cpuPkg::fetchOutT                   fetchOut,
   input  logic                               redirect,
   input  logic                               memBusy,
   input  cpuPkg::execOutT                    execOut,
   input  logic                               regWe,
   input  logic [cpuPkg::regIndexWidth-1:0]   regWaddr,
   input  logic [cpuPkg::dataWidth-1:0]       regWdata,
   input  logic                               retireWritesReg,
   input  logic [cpuPkg::regIndexWidth-1:0]   retireReg,
   output logic                               decodeStall,
   output cpuPkg::decodeOutT                  decodeOut
);

   logic [cpuPkg::dataWidth-1:0] regFile [cpuPkg::regCount];
   cpuPkg::opcodeT op;
   logic [cpuPkg::regIndexWidth-1:0] rd;
   logic [cpuPkg::regIndexWidth-1:0] rs;
   logic [cpuPkg::regIndexWidth-1:0] rt;
   logic [cpuPkg::dataWidth-1:0] immExt;
   logic readsRs;
   logic readsRt;
   logic readsRd;
   logic isRegOp;
   logic hazard;

   // Write before read, register 0 is always zero
   function automatic logic [cpuPkg::dataWidth-1:0] readReg(
      input logic [cpuPkg::regIndexWidth-1:0] idx);
      if (idx == '0)
         return '0;
      if (regWe && regWaddr == idx)
         return regWdata;
      return regFile[idx];
   endfunction

   // Register still owed by an older instruction in execute, memory or retiring
   function automatic logic pending(input logic [cpuPkg::regIndexWidth-1:0] idx);
      if (idx == '0)
         return 1'b0;
      return (decodeOut.valid && decodeOut.writesReg && decodeOut.rd == idx) ||
             (execOut.valid && execOut.writesReg && execOut.rd == idx) ||
             (retireWritesReg && retireReg == idx);
   endfunction

   always_comb begin
      op = cpuPkg::opcodeT'(fetchOut.instr[cpuPkg::opcodeLsb +: cpuPkg::opcodeWidth]);
      rd = fetchOut.instr[cpuPkg::rdLsb +: cpuPkg::regIndexWidth];
      rs = fetchOut.instr[cpuPkg::rsLsb +: cpuPkg::regIndexWidth];
      rt = fetchOut.instr[cpuPkg::rtLsb +: cpuPkg::regIndexWidth];
      immExt = {{(cpuPkg::dataWidth - cpuPkg::imm6Width){fetchOut.instr[cpuPkg::imm6Width-1]}},
                fetchOut.instr[cpuPkg::imm6Width-1:0]};
      isRegOp = op inside {cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND, cpuPkg::OP_XOR};
      readsRs = isRegOp || op inside {cpuPkg::OP_ADDI, cpuPkg::OP_LD, cpuPkg::OP_ST,
                                      cpuPkg::OP_BEQZ};
      readsRt = isRegOp;
      // ST stores rd
      readsRd = op == cpuPkg::OP_ST;
      hazard = fetchOut.valid && ((readsRs && pending(rs)) || (readsRt && pending(rt)) ||
                                  (readsRd && pending(rd)));
      decodeStall = memBusy || hazard;
   end

   always_ff @(posedge clk) begin
      if (regWe && regWaddr != '0)
         regFile[regWaddr] <= regWdata;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         decodeOut.valid <= 1'b0;
      end else if (!memBusy) begin
         if (redirect || hazard || !fetchOut.valid) begin
            decodeOut.valid <= 1'b0;
         end else begin
            decodeOut.valid <= 1'b1;
            decodeOut.pc <= fetchOut.pc;
            decodeOut.op <= op;
            decodeOut.rd <= rd;
            decodeOut.opA <= readReg(rs);
            decodeOut.opB <= isRegOp ? readReg(rt) : immExt;
            decodeOut.storeData <= readReg(rd);
            decodeOut.writesReg <= (isRegOp || op inside {cpuPkg::OP_ADDI, cpuPkg::OP_LD}) &&
                                   rd != '0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/executeStage.sv ====
// Execute stage computing ALU results and data addresses and resolving BEQZ
`timescale 1ns/10ps
`default_nettype none

module executeStage (
   input  logic                           clk,
   input  logic                           reset,
   input  cpuPkg::decodeOutT              decodeOut,
   input  logic                           memBusy,
   output logic                           redirect,
   output logic [cpuPkg::addrWidth-1:0]   redirectPc,
   output cpuPkg::execOutT                execOut
);

   logic [cpuPkg::dataWidth-1:0] result;
   logic [cpuPkg::addrWidth-2:0] dataOffset;
   logic [cpuPkg::addrWidth-1:0] dataAddr;

   always_comb begin
      // Offset wraps inside the data half
      dataOffset = decodeOut.opA[cpuPkg::addrWidth-2:0] + decodeOut.opB[cpuPkg::addrWidth-2:0];
      dataAddr = cpuPkg::addrWidth'(cpuPkg::dataBase) | {1'b0, dataOffset};
      case (decodeOut.op)
         cpuPkg::OP_ADD, cpuPkg::OP_ADDI: result = decodeOut.opA + decodeOut.opB;
         cpuPkg::OP_SUB:                  result = decodeOut.opA - decodeOut.opB;
         cpuPkg::OP_AND:                  result = decodeOut.opA & decodeOut.opB;
         cpuPkg::OP_XOR:                  result = decodeOut.opA ^ decodeOut.opB;
         cpuPkg::OP_LD, cpuPkg::OP_ST:    result = cpuPkg::dataWidth'(dataAddr);
         default:                         result = '0;
      endcase

      // Taken branch only counts in the cycle it moves on
      redirect = decodeOut.valid && decodeOut.op == cpuPkg::OP_BEQZ &&
                 decodeOut.opA == '0 && !memBusy;
      redirectPc = decodeOut.pc + 1'b1 + decodeOut.opB[cpuPkg::addrWidth-1:0];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         execOut.valid <= 1'b0;
      end else if (!memBusy) begin
         execOut.valid <= decodeOut.valid;
         execOut.pc <= decodeOut.pc;
         execOut.op <= decodeOut.op;
         execOut.rd <= decodeOut.rd;
         execOut.result <= result;
         execOut.storeData <= decodeOut.storeData;
         execOut.writesReg <= decodeOut.writesReg;
      end
   end

endmodule

`default_nettype wire

// ==== logic/fetchStage.sv ====
// Fetch stage keeping the PC, issuing instruction reads and filling the fetch-to-decode register
`timescale 1ns/10ps
`default_nettype none

module fetchStage (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           decodeStall,
   input  logic                           redirect,
   input  logic [cpuPkg::addrWidth-1:0]   redirectPc,
   input  logic                           halted,
   output cpuPkg::memReqT                 fetchReq,
   input  logic                           fetchGrant,
   input  logic [cpuPkg::dataWidth-1:0]   fetchRdata,
   input  logic                           fetchRvalid,
   output cpuPkg::fetchOutT               fetchOut
);

   logic [cpuPkg::addrWidth-1:0] pc;
   logic [cpuPkg::addrWidth-1:0] flightPc;
   logic inFlight;
   logic arrive;
   logic accept;

   always_comb begin
      // Output register is free or being handed to decode
      accept = !fetchOut.valid || !decodeStall;
      arrive = inFlight && fetchRvalid;
      // No new request while arriving data must be dropped and refetched
      fetchReq.valid = !halted && !redirect && !(arrive && !accept);
      fetchReq.write = 1'b0;
      fetchReq.addr = pc;
      fetchReq.wdata = '0;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= '0;
         inFlight <= 1'b0;
         fetchOut.valid <= 1'b0;
      end else begin
         inFlight <= fetchGrant;
         if (redirect)
            pc <= redirectPc;
         else if (arrive && !accept)
            pc <= flightPc;
         else if (fetchGrant)
            pc <= pc + 1'b1;

         // Redirect kills the held instruction and anything still in flight
         if (redirect) begin
            fetchOut.valid <= 1'b0;
         end else if (arrive && accept) begin
            fetchOut.valid <= 1'b1;
            fetchOut.pc <= flightPc;
            fetchOut.instr <= fetchRdata;
         end else if (!decodeStall) begin
            fetchOut.valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fetchGrant)
         flightPc <= pc;
   end

endmodule

`default_nettype wire

// ==== logic/memWbStage.sv ====
// Memory and write-back stage doing loads and stores, register writes and the retire trace
`timescale 1ns/10ps
`default_nettype none

module memWbStage (
   input  logic                               clk,
   input  logic                               reset,
   input  cpuPkg::execOutT                    execOut,
   output cpuPkg::memReqT                     dataReq,
   input  logic                               dataGrant,
   input  logic [cpuPkg::dataWidth-1:0]       dataRdata,
   input  logic                               dataRvalid,
   output logic                               memBusy,
   output logic                               regWe,
   output logic [cpuPkg::regIndexWidth-1:0]   regWaddr,
   output logic [cpuPkg::dataWidth-1:0]       regWdata,
   output logic                               retireWritesReg,
   output logic [cpuPkg::regIndexWidth-1:0]   retireReg,
   output cpuPkg::traceT                      trace,
   output logic                               halted,
   output logic                               err
);

   cpuPkg::execOutT item;
   logic waitData;
   logic isLoad;
   logic isStore;
   logic legal;
   logic illegal;
   logic retire;

   always_comb begin
      isLoad = item.valid && item.op == cpuPkg::OP_LD;
      isStore = item.valid && item.op == cpuPkg::OP_ST;
      legal = item.op inside {cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND, cpuPkg::OP_XOR,
                              cpuPkg::OP_ADDI, cpuPkg::OP_LD, cpuPkg::OP_ST, cpuPkg::OP_BEQZ,
                              cpuPkg::OP_HALT};
      illegal = item.valid && !halted && !legal;

      dataReq.valid = (isLoad || isStore) && !waitData && !halted;
      dataReq.write = isStore;
      dataReq.addr = item.result[cpuPkg::addrWidth-1:0];
      dataReq.wdata = item.storeData;

      // Store finishes on its grant, load when its data comes back
      if (!item.valid || halted || !legal)
         retire = 1'b0;
      else if (isLoad)
         retire = waitData && dataRvalid;
      else if (isStore)
         retire = dataGrant;
      else
         retire = 1'b1;

      memBusy = (isLoad || isStore) && !retire;
      regWe = retire && item.writesReg;
      regWaddr = item.rd;
      regWdata = isLoad ? dataRdata : item.result;
      retireWritesReg = regWe;
      retireReg = item.rd;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         item.valid <= 1'b0;
         waitData <= 1'b0;
         trace.valid <= 1'b0;
         halted <= 1'b0;
         err <= 1'b0;
      end else begin
         if (!memBusy)
            item <= execOut;
         waitData <= dataReq.valid && dataGrant && !dataReq.write;
         trace.valid <= retire;
         trace.pc <= item.pc;
         trace.writesReg <= item.writesReg;
         trace.destReg <= item.rd;
         trace.value <= regWdata;
         trace.writesMem <= isStore;
         trace.addr <= item.result[cpuPkg::addrWidth-1:0];
         trace.storeData <= item.storeData;
         halted <= halted || (retire && item.op == cpuPkg::OP_HALT) || illegal;
         err <= err || illegal;
      end
   end

endmodule

`default_nettype wire

// ==== logic/memoryArbiter.sv ====
// Fixed-priority arbiter sharing the memory among the loader, data and fetch requesters
`timescale 1ns/10ps
`default_nettype none

module memoryArbiter (
   input  logic                           clk,
   input  logic                           reset,
   input  cpuPkg::memReqT                 loadReq,
   input  cpuPkg::memReqT                 dataReq,
   input  cpuPkg::memReqT                 fetchReq,
   output logic                           loadGrant,
   output logic                           dataGrant,
   output logic                           fetchGrant,
   output cpuPkg::memReqT                 memReq,
   input  logic [cpuPkg::dataWidth-1:0]   memRdata,
   output logic [cpuPkg::dataWidth-1:0]   dataRdata,
   output logic                           dataRvalid,
   output logic [cpuPkg::dataWidth-1:0]   fetchRdata,
   output logic                           fetchRvalid
);

   // Owner of the read data that comes back next cycle
   logic dataOwns;
   logic fetchOwns;

   always_comb begin
      loadGrant = loadReq.valid;
      dataGrant = dataReq.valid && !loadReq.valid;
      fetchGrant = fetchReq.valid && !loadReq.valid && !dataReq.valid;
      if (loadGrant)
         memReq = loadReq;
      else if (dataGrant)
         memReq = dataReq;
      else
         memReq = fetchReq;
      dataRdata = memRdata;
      dataRvalid = dataOwns;
      fetchRdata = memRdata;
      fetchRvalid = fetchOwns;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         dataOwns <= 1'b0;
         fetchOwns <= 1'b0;
      end else begin
         dataOwns <= dataGrant && !dataReq.write;
         fetchOwns <= fetchGrant;
      end
   end

endmodule

`default_nettype wire

// ==== logic/pipelineCpu.sv ====
// Four-stage pipelined CPU top joining the stages, the memory arbiter and the unified memory
`timescale 1ns/10ps
`default_nettype none

module pipelineCpu (
   input  logic              clk,
   input  logic              reset,
   input  cpuPkg::memReqT    loadReq,
   output cpuPkg::traceT     trace,
   output logic              halted,
   output logic              err
);

   cpuPkg::memReqT fetchReq;
   cpuPkg::memReqT dataReq;
   cpuPkg::memReqT memReq;
   cpuPkg::fetchOutT fetchOut;
   cpuPkg::decodeOutT decodeOut;
   cpuPkg::execOutT execOut;
   logic fetchGrant;
   logic dataGrant;
   logic fetchRvalid;
   logic dataRvalid;
   logic decodeStall;
   logic redirect;
   logic memBusy;
   logic regWe;
   logic retireWritesReg;
   logic [cpuPkg::addrWidth-1:0] redirectPc;
   logic [cpuPkg::dataWidth-1:0] fetchRdata;
   logic [cpuPkg::dataWidth-1:0] dataRdata;
   logic [cpuPkg::dataWidth-1:0] memRdata;
   logic [cpuPkg::dataWidth-1:0] regWdata;
   logic [cpuPkg::regIndexWidth-1:0] regWaddr;
   logic [cpuPkg::regIndexWidth-1:0] retireReg;

   fetchStage i_fetchStage (
      .clk(clk), .reset(reset), .decodeStall(decodeStall), .redirect(redirect),
      .redirectPc(redirectPc), .halted(halted), .fetchReq(fetchReq), .fetchGrant(fetchGrant),
      .fetchRdata(fetchRdata), .fetchRvalid(fetchRvalid), .fetchOut(fetchOut));

   decodeStage i_decodeStage (
      .clk(clk), .reset(reset), .fetchOut(fetchOut), .redirect(redirect), .memBusy(memBusy),
      .execOut(execOut), .regWe(regWe), .regWaddr(regWaddr), .regWdata(regWdata),
      .retireWritesReg(retireWritesReg), .retireReg(retireReg), .decodeStall(decodeStall),
      .decodeOut(decodeOut));

   executeStage i_executeStage (
      .clk(clk), .reset(reset), .decodeOut(decodeOut), .memBusy(memBusy),
      .redirect(redirect), .redirectPc(redirectPc), .execOut(execOut));

   memWbStage i_memWbStage (
      .clk(clk), .reset(reset), .execOut(execOut), .dataReq(dataReq), .dataGrant(dataGrant),
      .dataRdata(dataRdata), .dataRvalid(dataRvalid), .memBusy(memBusy), .regWe(regWe),
      .regWaddr(regWaddr), .regWdata(regWdata), .retireWritesReg(retireWritesReg),
      .retireReg(retireReg), .trace(trace), .halted(halted), .err(err));

   // Loader has top priority and needs no grant back
   memoryArbiter i_memoryArbiter (
      .clk(clk), .reset(reset), .loadReq(loadReq), .dataReq(dataReq), .fetchReq(fetchReq),
      .loadGrant(), .dataGrant(dataGrant), .fetchGrant(fetchGrant), .memReq(memReq),
      .memRdata(memRdata), .dataRdata(dataRdata), .dataRvalid(dataRvalid),
      .fetchRdata(fetchRdata), .fetchRvalid(fetchRvalid));

   unifiedMemory i_unifiedMemory (
      .clk(clk), .memReq(memReq), .memRdata(memRdata));

endmodule

`default_nettype wire

// ==== logic/unifiedMemory.sv ====
// Unified 256-word single-port memory with synchronous read and write
`timescale 1ns/10ps
`default_nettype none

module unifiedMemory (
   input  logic                           clk,
   input  cpuPkg::memReqT                 memReq,
   output logic [cpuPkg::dataWidth-1:0]   memRdata
);

   logic [cpuPkg::dataWidth-1:0] mem [2**cpuPkg::addrWidth];

   // Read returns the value from before a same-cycle write
   always_ff @(posedge clk) begin
      if (memReq.valid) begin
         if (memReq.write)
            mem[memReq.addr] <= memReq.wdata;
         memRdata <= mem[memReq.addr];
      end
   end

endmodule

`default_nettype wire

// ==== pipelineCpu.f ====
logic/cpuPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWbStage.sv
logic/memoryArbiter.sv
logic/unifiedMemory.sv
logic/pipelineCpu.sv
testbench/pipelineCpuTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the CPU testbench with Verilator, run it and look for the pass message in the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module pipelineCpuTb -f pipelineCpu.f \
   -o pipelineCpuSim \
   && ./obj_dir/pipelineCpuSim | tee sim.log \
   && grep -qx "Done: no errors" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// ==== testbench/pipelineCpuTb.sv ====
// Testbench running random programs on the pipelined CPU against an instruction-level model
`timescale 1ns/10ps
`default_nettype none

module pipelineCpuTb;

   localparam int memWords = 2 ** cpuPkg::addrWidth;
   localparam int runCount = 5;
   localparam int runTimeout = 3000;
   localparam int quietCycles = 10;

   logic clk;
   logic reset;
   cpuPkg::memReqT loadReq;
   cpuPkg::traceT trace;
   logic halted;
   logic err;

   logic [31:0] lfsr;
   logic [cpuPkg::dataWidth-1:0] image [memWords];
   cpuPkg::traceT expected [$];
   logic expectErr;
   logic timedOut;
   int valueErrors;
   int otherErrors;
   int checkedEntries;

   pipelineCpu i_pipelineCpu (
      .clk(clk), .reset(reset), .loadReq(loadReq), .trace(trace), .halted(halted), .err(err));

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32, 22, 2 and 1
   function automatic logic [31:0] nextBits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         value = {value[30:0], lfsr[0]};
      end
      return value;
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   // Seven ADDIs set r1 to r7, then a random body and a final HALT
   task automatic buildProgram(input int run);
      int bodyLen;
      int haltIdx;
      int badIdx;
      int maxOff;
      logic [3:0] op;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [5:0] imm;
      bodyLen = 8 + int'(nextBits(5)) % 25;
      haltIdx = 7 + bodyLen;
      // Odd runs carry one illegal opcode
      badIdx = (run % 2 == 1) ? 7 + int'(nextBits(5)) % bodyLen : -1;
      for (int a = 0; a < memWords; a++) begin
         if (a < 7) begin
            image[a] = {cpuPkg::OP_ADDI, 3'(a + 1), 3'd0, 6'(nextBits(6))};
         end else if (a == badIdx) begin
            op = 4'(9 + nextBits(3) % 7);
            image[a] = {op, 12'(nextBits(12))};
         end else if (a < haltIdx) begin
            op = 4'(nextBits(3));
            rd = 3'(nextBits(3));
            rs = 3'(nextBits(3));
            rt = 3'(nextBits(3));
            imm = 6'(nextBits(6));
            if (op == cpuPkg::OP_BEQZ) begin
               maxOff = haltIdx - a - 1;
               if (maxOff > 31)
                  maxOff = 31;
               imm = 6'(int'(nextBits(5)) % (maxOff + 1));
               // Half of the branches test r0 and are always taken
               if (nextBits(1) == 1)
                  rs = 3'd0;
               image[a] = {op, 3'd0, rs, imm};
            end else if (op <= cpuPkg::OP_XOR) begin
               image[a] = {op, rd, rs, rt, 3'd0};
            end else begin
               image[a] = {op, rd, rs, imm};
            end
         end else if (a == haltIdx) begin
            image[a] = {cpuPkg::OP_HALT, 12'd0};
         end else if (a < cpuPkg::dataBase) begin
            // Unused code words are HALTs tagged with their address
            image[a] = {cpuPkg::OP_HALT, 4'd0, 8'(a)};
         end else begin
            image[a] = 16'(nextBits(16));
         end
      end
   endtask

   // Executes the image one instruction at a time and queues the expected trace
   task automatic runModel();
      logic [cpuPkg::dataWidth-1:0] mem [memWords];
      logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];
      logic [cpuPkg::dataWidth-1:0] instr;
      logic [cpuPkg::dataWidth-1:0] a;
      logic [cpuPkg::dataWidth-1:0] b;
      logic [cpuPkg::dataWidth-1:0] imm;
      logic [cpuPkg::dataWidth-1:0] value;
      logic [cpuPkg::addrWidth-1:0] pc;
      logic [cpuPkg::addrWidth-1:0] dataAddr;
      cpuPkg::traceT entry;
      logic done;
      int steps;
      mem = image;
      for (int i = 0; i < cpuPkg::regCount; i++)
         regs[i] = '0;
      expected.delete();
      expectErr = 1'b0;
      done = 1'b0;
      pc = '0;
      steps = 0;
      while (!done && steps < memWords) begin
         instr = mem[pc];
         a = regs[instr[8:6]];
         b = regs[instr[5:3]];
         imm = {{10{instr[5]}}, instr[5:0]};
         dataAddr = 8'(cpuPkg::dataBase + ((a + imm) & 16'h007f));
         entry = '0;
         entry.valid = 1'b1;
         entry.pc = pc;
         entry.destReg = instr[11:9];
         value = '0;
         pc = pc + 8'd1;
         case (instr[15:12])
            cpuPkg::OP_ADD:  value = a + b;
            cpuPkg::OP_SUB:  value = a - b;
            cpuPkg::OP_AND:  value = a & b;
            cpuPkg::OP_XOR:  value = a ^ b;
            cpuPkg::OP_ADDI: value = a + imm;
            cpuPkg::OP_LD:   value = mem[dataAddr];
            cpuPkg::OP_ST: begin
               entry.writesMem = 1'b1;
               entry.addr = dataAddr;
               entry.storeData = regs[instr[11:9]];
               mem[dataAddr] = regs[instr[11:9]];
            end
            cpuPkg::OP_BEQZ: begin
               if (a == '0)
                  pc = pc + 8'(instr[5:0]);
            end
            cpuPkg::OP_HALT: done = 1'b1;
            default: begin
               expectErr = 1'b1;
               done = 1'b1;
            end
         endcase
         // ADD through LD write rd, and r0 stays zero
         if (instr[15:12] <= cpuPkg::OP_LD && instr[11:9] != '0) begin
            entry.writesReg = 1'b1;
            entry.value = value;
            regs[instr[11:9]] = value;
         end
         if (!expectErr)
            expected.push_back(entry);
         steps++;
      end
   endtask

   // Memory image goes in through the loader port while the core is in reset
   task automatic loadImage();
      reset = 1'b1;
      repeat (4) tick();
      for (int a = 0; a < memWords; a++) begin
         loadReq.valid = 1'b1;
         loadReq.write = 1'b1;
         loadReq.addr = 8'(a);
         loadReq.wdata = image[a];
         tick();
      end
      loadReq = '0;
      tick();
      reset = 1'b0;
   endtask

   task automatic checkEntry(input int run);
      cpuPkg::traceT want;
      if (expected.size() == 0) begin
         $display("Run %0d retired pc %0d past the end of the expected trace", run, trace.pc);
         otherErrors++;
      end else begin
         want = expected.pop_front();
         if (trace.pc != want.pc || trace.writesReg != want.writesReg ||
             trace.writesMem != want.writesMem) begin
            $display("Error at %0t: run %0d pc %0d (wr %b st %b), expected pc %0d (wr %b st %b)",
                     $time, run, trace.pc, trace.writesReg, trace.writesMem,
                     want.pc, want.writesReg, want.writesMem);
            valueErrors++;
         end else if (want.writesReg &&
                      (trace.destReg != want.destReg || trace.value != want.value)) begin
            $display("Error at %0t: pc %0d wrote r%0d = %h, expected r%0d = %h",
                     $time, trace.pc, trace.destReg, trace.value, want.destReg, want.value);
            valueErrors++;
         end else if (want.writesMem &&
                      (trace.addr != want.addr || trace.storeData != want.storeData)) begin
            $display("Error at %0t: pc %0d stored %h at %0d, expected %h at %0d",
                     $time, trace.pc, trace.storeData, trace.addr, want.storeData, want.addr);
            valueErrors++;
         end
         checkedEntries++;
      end
   endtask

   task automatic checkRun(input int run);
      int cycles;
      cycles = 0;
      while (!halted && cycles < runTimeout) begin
         tick();
         cycles++;
         if (trace.valid)
            checkEntry(run);
      end
      if (!halted) begin
         $display("Run %0d did not halt within %0d cycles", run, runTimeout);
         otherErrors++;
         timedOut = 1'b1;
      end else begin
         // Nothing may retire once halted is up
         repeat (quietCycles) begin
            tick();
            if (trace.valid) begin
               $display("Run %0d retired pc %0d after halting", run, trace.pc);
               otherErrors++;
            end
         end
         if (expected.size() != 0) begin
            $display("Run %0d halted with %0d expected instructions not retired",
                     run, expected.size());
            otherErrors++;
         end
         if (err != expectErr) begin
            $display("Error at %0t: run %0d ended with err %b, expected %b",
                     $time, run, err, expectErr);
            valueErrors++;
         end
      end
   endtask

   initial begin
      reset = 1'b1;
      loadReq = '0;
      lfsr = 32'he93;
      timedOut = 1'b0;
      valueErrors = 0;
      otherErrors = 0;
      checkedEntries = 0;
      for (int run = 0; run < runCount && !timedOut; run++) begin
         buildProgram(run);
         runModel();
         loadImage();
         checkRun(run);
      end
      $display("Checked %0d trace entries: %0d value errors, %0d other errors",
               checkedEntries, valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire
